/* src/ffcp_macros.svh */
// FFCP receive path widths and protocol constants
`ifndef FFCP_MACROS_SVH
`define FFCP_MACROS_SVH

`define BYTE_LEN 8

// Ethernet header layout, in bytes
`define ETH_HEADER_LEN 14
`define ETH_ETHERTYPE_POS 12

`define ETHERTYPE_FFCP 16'h8855

// Slot index carried in the FFCP header
`define FFCP_INDEX_LEN 4

// Payload bytes per packet buffer slot
`define FGP_LEN 16
`define FGP_CNT_LEN 4

// Slot and offset together
`define PB_ADDR_LEN 8

// Preamble is 0x55 bytes, delimiter 0xD5, sent LSB first
`define RMII_PREAMBLE_DIBIT 2'b01
`define RMII_SFD_DIBIT 2'b11

`endif

/* src/eth_pkg.sv */
// Ethernet receive types for the RMII line and the framing stages
`include "ffcp_macros.svh"

package eth_pkg;

	// RMII receive pins as sampled on clk
	typedef struct packed {
		logic crs_dv;
		logic [1:0] rxd;
		logic rxerr;
	} rmii_rx_t;

	// One byte with its strobe
	typedef struct packed {
		logic valid;
		logic [`BYTE_LEN-1:0] data;
	} byte_strobe_t;

	// High byte first, as on the wire
	typedef logic [2*`BYTE_LEN-1:0] ethertype_t;

endpackage

/* src/ffcp_pkg.sv */
// FFCP metadata and packet buffer write port types
`include "ffcp_macros.svh"

package ffcp_pkg;

	typedef enum logic [`BYTE_LEN-1:0] {
		FFCP_TYPE_ACK = 8'd1,
		FFCP_TYPE_SYN = 8'd2,
		FFCP_TYPE_MSG = 8'd3
	} ffcp_type_e;

	// Header strobe with the decoded type and slot index
	typedef struct packed {
		logic valid;
		ffcp_type_e ffcp_type;
		logic [`FFCP_INDEX_LEN-1:0] index;
	} ffcp_meta_t;

	typedef struct packed {
		logic [`FFCP_INDEX_LEN-1:0] slot;
		logic [`FGP_CNT_LEN-1:0] offset;
	} pb_slot_addr_t;

	// Same word seen as slot and offset, or as a flat buffer address
	typedef union packed {
		logic [`PB_ADDR_LEN-1:0] flat;
		pb_slot_addr_t fields;
	} pb_addr_u;

	typedef struct packed {
		logic we;
		pb_addr_u addr;
		logic [`BYTE_LEN-1:0] data;
	} pb_write_t;

endpackage

/* src/rmii_byte_rx.sv */
// RMII receiver that locks on the start-frame delimiter and packs dibits into bytes
`timescale 1ns/1ps
`include "ffcp_macros.svh"

module rmii_byte_rx import eth_pkg::*; (
	input logic clk,
	input logic eth_rx_downstream_rst,
	input rmii_rx_t rmii,
	output byte_strobe_t rx_byte,
	output logic frame_end,
	output logic frame_abort
);
	typedef enum logic [1:0] {ST_IDLE, ST_PREAMBLE, ST_DATA} state_e;

	state_e state;
	logic crs_dv_q;
	logic [1:0] dibit_cnt;
	logic byte_valid;
	logic [`BYTE_LEN-1:0] shift;

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			state <= ST_IDLE;
			crs_dv_q <= 1'b0;
			dibit_cnt <= '0;
			byte_valid <= 1'b0;
			frame_end <= 1'b0;
			frame_abort <= 1'b0;
		end else begin
			crs_dv_q <= rmii.crs_dv;
			byte_valid <= 1'b0;
			frame_end <= 1'b0;
			frame_abort <= 1'b0;
			case (state)
				ST_IDLE: begin
					// Only a fresh carrier can start a frame
					if (rmii.crs_dv && !crs_dv_q && rmii.rxd == `RMII_PREAMBLE_DIBIT)
						state <= ST_PREAMBLE;
				end
				ST_PREAMBLE: begin
					if (!rmii.crs_dv || rmii.rxerr) begin
						frame_abort <= rmii.rxerr;
						state <= ST_IDLE;
					end else if (rmii.rxd == `RMII_SFD_DIBIT) begin
						dibit_cnt <= '0;
						state <= ST_DATA;
					end else if (rmii.rxd != `RMII_PREAMBLE_DIBIT) begin
						state <= ST_IDLE;
					end
				end
				ST_DATA: begin
					if (rmii.rxerr) begin
						frame_abort <= 1'b1;
						state <= ST_IDLE;
					end else if (!rmii.crs_dv) begin
						frame_end <= 1'b1;
						state <= ST_IDLE;
					end else begin
						dibit_cnt <= dibit_cnt + 2'd1;
						byte_valid <= (dibit_cnt == 2'd3);
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// LSB first, so new dibits enter at the top
	always_ff @(posedge clk) begin
		if (state == ST_DATA && rmii.crs_dv)
			shift <= {rmii.rxd, shift[`BYTE_LEN-1:2]};
	end

	assign rx_byte = '{valid: byte_valid, data: shift};

endmodule

/* src/eth_frame_rx.sv */
// Ethernet header parser that extracts the ethertype and forwards payload bytes
`timescale 1ns/1ps
`include "ffcp_macros.svh"

module eth_frame_rx import eth_pkg::*; (
	input logic clk,
	input logic eth_rx_downstream_rst,
	input byte_strobe_t rx_byte,
	input logic frame_end,
	input logic frame_abort,
	output byte_strobe_t payload,
	output ethertype_t ethertype,
	output logic ethertype_valid,
	output logic payload_end
);
	localparam int HDR_CNT_LEN = $clog2(`ETH_HEADER_LEN + 1);
	localparam logic [HDR_CNT_LEN-1:0] HDR_END = HDR_CNT_LEN'(`ETH_HEADER_LEN);
	localparam logic [HDR_CNT_LEN-1:0] ET_HI_POS = HDR_CNT_LEN'(`ETH_ETHERTYPE_POS);
	localparam logic [HDR_CNT_LEN-1:0] ET_LO_POS = HDR_CNT_LEN'(`ETH_ETHERTYPE_POS + 1);

	logic [HDR_CNT_LEN-1:0] hdr_cnt;
	logic [`BYTE_LEN-1:0] ethertype_hi;
	ethertype_t ethertype_q;
	logic payload_valid;
	logic [`BYTE_LEN-1:0] payload_data;

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			hdr_cnt <= '0;
			payload_valid <= 1'b0;
			ethertype_valid <= 1'b0;
			payload_end <= 1'b0;
		end else begin
			payload_valid <= 1'b0;
			ethertype_valid <= 1'b0;
			payload_end <= frame_end;
			if (frame_abort || frame_end) begin
				hdr_cnt <= '0;
			end else if (rx_byte.valid) begin
				// Counter stops at the header length, the rest is payload
				if (hdr_cnt == HDR_END)
					payload_valid <= 1'b1;
				else
					hdr_cnt <= hdr_cnt + 1'b1;
				if (hdr_cnt == ET_LO_POS)
					ethertype_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rx_byte.valid) begin
			payload_data <= rx_byte.data;
			if (hdr_cnt == ET_HI_POS)
				ethertype_hi <= rx_byte.data;
			if (hdr_cnt == ET_LO_POS)
				ethertype_q <= {ethertype_hi, rx_byte.data};
		end
	end

	assign ethertype = ethertype_q;
	assign payload = '{valid: payload_valid, data: payload_data};

endmodule

/* src/ffcp_rx.sv */
// FFCP header decoder that filters on ethertype and classifies ACK, SYN and MSG frames
`timescale 1ns/1ps
`include "ffcp_macros.svh"

module ffcp_rx import eth_pkg::*, ffcp_pkg::*; (
	input logic clk,
	input logic eth_rx_downstream_rst,
	input byte_strobe_t payload,
	input ethertype_t ethertype,
	input logic ethertype_valid,
	input logic payload_end,
	input logic frame_abort,
	output ffcp_meta_t meta,
	output byte_strobe_t ffcp_payload,
	output logic frame_done
);
	typedef enum logic [1:0] {FIELD_TYPE, FIELD_INDEX, FIELD_DATA} field_e;

	field_e field;
	logic ffcp_en;
	logic accepted;
	logic type_known;
	ffcp_type_e type_q;
	logic [`FFCP_INDEX_LEN-1:0] index_q;
	logic meta_valid;
	logic fwd_valid;
	logic [`BYTE_LEN-1:0] fwd_data;

	always_comb type_known = type_q inside {FFCP_TYPE_ACK, FFCP_TYPE_SYN, FFCP_TYPE_MSG};

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			field <= FIELD_TYPE;
			ffcp_en <= 1'b0;
			accepted <= 1'b0;
			meta_valid <= 1'b0;
			fwd_valid <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			meta_valid <= 1'b0;
			fwd_valid <= 1'b0;
			frame_done <= payload_end && accepted;
			if (frame_abort || payload_end) begin
				field <= FIELD_TYPE;
				ffcp_en <= 1'b0;
				accepted <= 1'b0;
			end else begin
				if (ethertype_valid)
					ffcp_en <= (ethertype == `ETHERTYPE_FFCP);
				if (payload.valid && ffcp_en) begin
					case (field)
						FIELD_TYPE: field <= FIELD_INDEX;
						FIELD_INDEX: begin
							// Unknown types are dropped here
							field <= FIELD_DATA;
							meta_valid <= type_known;
							accepted <= type_known;
						end
						default: fwd_valid <= accepted;
					endcase
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (payload.valid) begin
			fwd_data <= payload.data;
			if (field == FIELD_TYPE)
				type_q <= ffcp_type_e'(payload.data);
			if (field == FIELD_INDEX)
				index_q <= payload.data[`FFCP_INDEX_LEN-1:0];
		end
	end

	assign meta = '{valid: meta_valid, ffcp_type: type_q, index: index_q};
	assign ffcp_payload = '{valid: fwd_valid, data: fwd_data};

endmodule

/* src/ffcp_slot_writer.sv */
// Packet buffer writer that places FFCP payload bytes in the slot given by the index
`timescale 1ns/1ps
`include "ffcp_macros.svh"

module ffcp_slot_writer import eth_pkg::*, ffcp_pkg::*; (
	input logic clk,
	input logic eth_rx_downstream_rst,
	input ffcp_meta_t meta,
	input byte_strobe_t ffcp_payload,
	input logic frame_abort,
	output pb_write_t pb_write
);
	localparam logic [`FGP_CNT_LEN-1:0] LAST_OFFSET = `FGP_CNT_LEN'(`FGP_LEN - 1);

	logic [`FFCP_INDEX_LEN-1:0] slot_q;
	logic [`FGP_CNT_LEN-1:0] offset_cnt;
	logic slot_full;
	logic wr_en;
	pb_addr_u wr_addr;
	logic [`BYTE_LEN-1:0] wr_data;

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			offset_cnt <= '0;
			slot_full <= 1'b0;
			wr_en <= 1'b0;
		end else begin
			wr_en <= 1'b0;
			if (meta.valid || frame_abort) begin
				offset_cnt <= '0;
				slot_full <= 1'b0;
			end else if (ffcp_payload.valid && !slot_full) begin
				wr_en <= 1'b1;
				offset_cnt <= offset_cnt + 1'b1;
				// Bytes past one slot are dropped
				if (offset_cnt == LAST_OFFSET)
					slot_full <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (meta.valid)
			slot_q <= meta.index;
		if (ffcp_payload.valid) begin
			wr_addr.fields.slot <= slot_q;
			wr_addr.fields.offset <= offset_cnt;
			wr_data <= ffcp_payload.data;
		end
	end

	assign pb_write = '{we: wr_en, addr: wr_addr, data: wr_data};

endmodule

/* src/eth_ffcp_rx_top.sv */
// Ethernet FFCP receive chain from the RMII line to packet buffer writes
`timescale 1ns/1ps

module eth_ffcp_rx_top import eth_pkg::*, ffcp_pkg::*; (
	input logic clk,
	input logic eth_rx_downstream_rst,
	input rmii_rx_t rmii,
	output ffcp_meta_t meta,
	output logic frame_done,
	output pb_write_t pb_write
);
	byte_strobe_t rx_byte;
	logic frame_end;
	logic frame_abort;
	byte_strobe_t payload;
	ethertype_t ethertype;
	logic ethertype_valid;
	logic payload_end;
	byte_strobe_t ffcp_payload;

	rmii_byte_rx u_rmii_byte_rx (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.rmii(rmii),
		.rx_byte(rx_byte),
		.frame_end(frame_end),
		.frame_abort(frame_abort)
	);

	eth_frame_rx u_eth_frame_rx (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.rx_byte(rx_byte),
		.frame_end(frame_end),
		.frame_abort(frame_abort),
		.payload(payload),
		.ethertype(ethertype),
		.ethertype_valid(ethertype_valid),
		.payload_end(payload_end)
	);

	ffcp_rx u_ffcp_rx (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.payload(payload),
		.ethertype(ethertype),
		.ethertype_valid(ethertype_valid),
		.payload_end(payload_end),
		.frame_abort(frame_abort),
		.meta(meta),
		.ffcp_payload(ffcp_payload),
		.frame_done(frame_done)
	);

	ffcp_slot_writer u_ffcp_slot_writer (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.meta(meta),
		.ffcp_payload(ffcp_payload),
		.frame_abort(frame_abort),
		.pb_write(pb_write)
	);

endmodule

/* tb/tb_eth_ffcp_rx.sv */
// Testbench for the FFCP receive path, driving RMII frames listed in a stimulus file
`timescale 1ns/1ps
`include "ffcp_macros.svh"

module tb_eth_ffcp_rx import eth_pkg::*, ffcp_pkg::*; ();
	localparam int TIMEOUT_CYCLES = 400;
	localparam int IDLE_GAP = 12;

	typedef enum logic [1:0] {EV_META, EV_WRITE, EV_DONE} ev_kind_e;

	logic clk;
	logic eth_rx_downstream_rst;
	rmii_rx_t rmii;
	ffcp_meta_t meta;
	logic frame_done;
	pb_write_t pb_write;

	ev_kind_e ev_q[$];
	ffcp_meta_t meta_q[$];
	pb_write_t wr_q[$];
	logic [`BYTE_LEN-1:0] frame_q[$];
	logic [`BYTE_LEN-1:0] payload_q[$];
	int done_cnt;
	int seed;

	eth_ffcp_rx_top dut (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.rmii(rmii),
		.meta(meta),
		.frame_done(frame_done),
		.pb_write(pb_write)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Event log of meta strobes, buffer writes and done pulses
	initial done_cnt = 0;
	always @(negedge clk) begin
		if (!eth_rx_downstream_rst) begin
			if (meta.valid) begin
				ev_q.push_back(EV_META);
				meta_q.push_back(meta);
			end
			if (pb_write.we) begin
				ev_q.push_back(EV_WRITE);
				wr_q.push_back(pb_write);
			end
			if (frame_done) begin
				ev_q.push_back(EV_DONE);
				done_cnt++;
			end
		end
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_meta(input ffcp_meta_t got, input ffcp_meta_t exp);
		if (got !== exp)
			fail_run($sformatf(
				"mismatch at time %0t: meta type %0d index %0h, expected type %0d index %0h",
				$time, got.ffcp_type, got.index, exp.ffcp_type, exp.index));
	endtask

	task automatic check_write(input pb_write_t got, input pb_write_t exp);
		if (got !== exp)
			fail_run($sformatf(
				"mismatch at time %0t: write addr %0h data %0h, expected addr %0h data %0h",
				$time, got.addr.flat, got.data, exp.addr.flat, exp.data));
	endtask

	task automatic check_done(input logic got, input logic exp, input string what);
		if (got !== exp)
			fail_run($sformatf("mismatch at time %0t: %s is %0b, expected %0b",
				$time, what, got, exp));
	endtask

	task automatic expect_event(input ev_kind_e kind, input string what);
		if (ev_q.size() == 0)
			fail_run($sformatf("the DUT gave no %s", what));
		else if (ev_q[0] != kind)
			fail_run($sformatf("DUT events came out of order where a %s was due", what));
		else
			ev_q.delete(0);
	endtask

	task automatic send_byte(input logic [`BYTE_LEN-1:0] b, input logic err);
		for (int i = 0; i < 4; i++) begin
			@(posedge clk);
			rmii <= '{crs_dv: 1'b1, rxd: b[2*i +: 2], rxerr: err && i == 0};
		end
	endtask

	task automatic send_idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			rmii <= '{crs_dv: 1'b0, rxd: 2'b00, rxerr: 1'b0};
		end
	endtask

	task automatic run_frame(input int ethertype, input int type_b, input int index_b,
			input int len, input int abort_pos, input int accept);
		ffcp_meta_t exp_meta;
		pb_write_t exp_wr;
		int n_wr;
		int done_base;
		int cycles;
		frame_q.delete();
		payload_q.delete();
		// Destination and source MAC, then ethertype, type and index
		for (int i = 0; i < 12; i++)
			frame_q.push_back(8'(i + 'h20));
		frame_q.push_back(8'(ethertype >> 8));
		frame_q.push_back(8'(ethertype));
		frame_q.push_back(8'(type_b));
		frame_q.push_back(8'(index_b));
		for (int i = 0; i < len; i++) begin
			payload_q.push_back(8'($random(seed)));
			frame_q.push_back(payload_q[i]);
		end
		done_base = done_cnt;
		repeat (7) send_byte(8'h55, 1'b0);
		send_byte(8'hd5, 1'b0);
		// Abort positions count bytes from 1 after the delimiter
		for (int i = 0; i < frame_q.size(); i++) begin
			send_byte(frame_q[i], abort_pos == i + 1);
			if (abort_pos == i + 1)
				break;
		end
		send_idle(1);
		cycles = 0;
		while (accept != 0 && done_cnt == done_base && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			cycles++;
		end
		if (accept != 0 && done_cnt == done_base)
			fail_run("timed out waiting for frame_done");
		send_idle(IDLE_GAP);

		exp_meta = '{valid: 1'b1, ffcp_type: ffcp_type_e'(8'(type_b)),
			index: index_b[`FFCP_INDEX_LEN-1:0]};
		n_wr = (len < `FGP_LEN) ? len : `FGP_LEN;
		if (accept == 0) begin
			check_done(done_cnt != done_base, 1'b0, "frame_done for a rejected frame");
			if (ev_q.size() != 0)
				fail_run("a rejected frame gave a meta event or a buffer write");
		end else begin
			expect_event(EV_META, "meta event");
			check_meta(meta_q.pop_front(), exp_meta);
			for (int i = 0; i < n_wr; i++) begin
				expect_event(EV_WRITE, "buffer write");
				exp_wr.we = 1'b1;
				exp_wr.addr.flat = `PB_ADDR_LEN'(int'(exp_meta.index) * `FGP_LEN + i);
				exp_wr.data = payload_q[i];
				check_write(wr_q.pop_front(), exp_wr);
			end
			if (ev_q.size() == 0)
				fail_run("frame_done never followed the last write");
			check_done(ev_q[0] == EV_DONE, 1'b1, "frame_done after the last write");
			ev_q.delete(0);
			if (ev_q.size() != 0)
				fail_run("the DUT gave more events after frame_done");
		end
	endtask

	initial begin
		int fd;
		int rc;
		int frame_cnt;
		int f_ethertype;
		int f_type;
		int f_index;
		int f_len;
		int f_abort;
		int f_accept;
		string line;
		seed = 32'h02bf_8327;
		frame_cnt = 0;
		eth_rx_downstream_rst <= 1'b1;
		rmii <= '0;
		fd = $fopen("tb/ffcp_rx_stim.txt", "r");
		if (fd == 0)
			fail_run("cannot open the stimulus file tb/ffcp_rx_stim.txt");
		repeat (3) @(posedge clk);
		eth_rx_downstream_rst <= 1'b0;
		send_idle(4);
		while (!$feof(fd)) begin
			rc = $fgets(line, fd);
			if (rc > 0 && line.getc(0) != "#") begin
				rc = $sscanf(line, "%h %h %h %d %d %d", f_ethertype, f_type, f_index,
					f_len, f_abort, f_accept);
				if (rc == 6) begin
					run_frame(f_ethertype, f_type, f_index, f_len, f_abort, f_accept);
					frame_cnt++;
				end
			end
		end
		$fclose(fd);
		if (frame_cnt == 0) begin
			fail_run("the stimulus file held no frames");
		end else begin
			$display("%0d frames checked", frame_cnt);
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

/* tb/ffcp_rx_stim.txt */
# ethertype(hex) type(hex) index(hex) payload_len abort_byte expect_accept
# abort_byte counts from 1 after the delimiter, 0 means no rxerr
8855 03 a5 8 0 1
8855 01 0a 4 0 1
8855 02 13 6 0 1
0800 03 02 8 0 0
8855 03 07 20 0 1
8855 03 04 5 6 0
8855 03 04 5 0 1
8855 07 04 5 0 0
8855 00 01 3 0 0
86dd 01 01 3 0 0
8855 03 0f 16 0 1
8855 02 00 0 0 1
8855 03 0c 3 13 0
8855 01 0c 3 14 0
8855 03 09 24 0 1
8856 03 09 4 0 0
8855 ff 02 4 0 0
8855 02 3e 10 1 0
8855 01 3e 10 0 1
8855 03 06 2 0 1
0806 02 06 7 0 0
8855 03 b1 17 0 1

/* tb.f */
+incdir+src
src/eth_pkg.sv
src/ffcp_pkg.sv
src/rmii_byte_rx.sv
src/eth_frame_rx.sv
src/ffcp_rx.sv
src/ffcp_slot_writer.sv
src/eth_ffcp_rx_top.sv
tb/tb_eth_ffcp_rx.sv

/* Makefile */
# Verilator build and run of the FFCP receive path testbench

.PHONY: sim clean

sim:
	verilator --binary --timing -f tb.f --top-module tb_eth_ffcp_rx -Mdir obj_dir
	./obj_dir/Vtb_eth_ffcp_rx | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
